/* rtl/fetch_direction_predictor.sv */
//**************************************************************************
// global-history direction predictor with two-bit saturating counters
// the counter table is indexed by the global history alone, so every
// branch sharing a history value shares one counter
// counters start weakly not taken (1), history starts at zero
// an update writes the step of the counter seen at prediction time, not
// the current table contents
//**************************************************************************

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_direction_predictor (
    input  logic                      clk,
    input  logic                      reset,
    output fetch_pkg::fetch_counter_t prediction,
    input  logic                      update_valid,
    input  logic                      branched,
    input  fetch_pkg::fetch_counter_t history_at_predict
);

    localparam int DEPTH = 1 << `FETCH_HISTORY_WIDTH;

    fetch_pkg::fetch_counter_t counter_q [DEPTH];
    fetch_pkg::fetch_history_t history_q;
    fetch_pkg::fetch_counter_t counter_next;

    // saturating step of a two-bit counter
    function automatic fetch_pkg::fetch_counter_t counter_step(
        input fetch_pkg::fetch_counter_t value,
        input logic                      taken
    );
        fetch_pkg::fetch_counter_t result;
        result = value;
        if (taken && value != 2'd3) begin
            result = value + 2'd1;
        end else if (!taken && value != 2'd0) begin
            result = value - 2'd1;
        end
        return result;
    endfunction

    assign prediction   = counter_q[history_q];
    assign counter_next = counter_step(history_at_predict, branched);

    always_ff @(posedge clk) begin
        if (reset) begin
            history_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                counter_q[i] <= 2'd1;
            end
        end else if (update_valid) begin
            // written at the history in use before the shift
            counter_q[history_q] <= counter_next;
            history_q            <= {history_q[`FETCH_HISTORY_WIDTH-2:0], branched};
        end
    end

endmodule

/* rtl/fetch_output_stage.sv */
//**************************************************************************
// registered valid/ready stage with a two-entry skid buffer
// in_ready depends only on the fill level, never on out_ready
// data and valid appear one cycle after the input transfer
// full throughput while out_ready stays high
//**************************************************************************

`timescale 1ns/1ps

module fetch_output_stage #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;
    logic             out_free;

    // main register empty or being read this cycle
    assign out_free = !out_valid || out_ready;
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // skid drains first, input is blocked while it is full
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!out_free && in_valid && !skid_valid) begin
            skid_data <= in_data;
        end
    end

endmodule

/* rtl/fetch_pc_unit.sv */
//**************************************************************************
// pc register, next-pc choice and the control of both output streams
// a command and its memory request are always offered and taken together,
// so neither stream can run ahead of the other
// jump commands are always accepted, ones marked mispredicted are ignored
// halt is sticky until reset
//**************************************************************************

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_pc_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           jump_valid,
    input  fetch_pkg::fetch_jump_t         jump,
    output fetch_pkg::fetch_pc_t           lookup_pc,
    input  fetch_pkg::fetch_target_entry_t entry,
    input  logic                           hit,
    input  logic                           table_ready,
    input  fetch_pkg::fetch_counter_t      counter,
    output logic                           table_write_valid,
    output logic                           cmd_valid,
    output fetch_pkg::fetch_command_t      cmd,
    input  logic                           cmd_ready,
    output logic                           req_valid,
    output fetch_pkg::fetch_pc_t           req_addr,
    input  logic                           req_ready
);

    fetch_pkg::fetch_pc_t pc;
    fetch_pkg::fetch_pc_t pc_next;
    logic                 pc_updated;
    logic                 pc_updated_next;
    logic                 halted;
    logic                 produce;
    logic                 enable;
    logic                 predicted_taken;

    always_comb begin
        // the only place where mispredicted is looked at
        table_write_valid = jump_valid && !jump.mispredicted;

        produce = !halted && table_ready;
        enable  = cmd_ready && req_ready;

        cmd_valid = produce && enable;
        req_valid = produce && enable;

        lookup_pc       = pc;
        predicted_taken = hit && (counter[1] || entry.is_jump);

        pc_next         = pc;
        pc_updated_next = pc_updated;

        if (produce && enable) begin
            if (predicted_taken) begin
                pc_next = entry.target;
            end else begin
                pc_next = pc + fetch_pkg::fetch_pc_t'(4);
            end
            pc_updated_next = 1'b0;
        end

        // redirect from execute wins over any prediction
        if (table_write_valid && jump.update_pc) begin
            pc_next         = jump.actual_next_pc;
            pc_updated_next = 1'b1;
        end

        cmd.pc                 = pc;
        cmd.next_pc            = pc_next;
        cmd.pc_updated         = pc_updated;
        cmd.prediction.hit     = hit;
        cmd.prediction.counter = counter;

        req_addr = pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `FETCH_START_ADDR;
            pc_updated <= 1'b0;
            halted     <= 1'b0;
        end else begin
            pc         <= pc_next;
            pc_updated <= pc_updated_next;
            if (table_write_valid && jump.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* rtl/fetch_pkg.sv */
//**************************************************************************
// types shared by the fetch stage and its predictors
// widths come from the settings header, which must be on the include path
// the tag covers pc bits above the table index, pc[1:0] is never stored
//**************************************************************************

`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [`FETCH_PC_WIDTH-1:0] fetch_pc_t;
    typedef logic [`FETCH_TABLE_ADDR_WIDTH-1:0] fetch_table_index_t;
    typedef logic [`FETCH_PC_WIDTH-`FETCH_TABLE_ADDR_WIDTH-3:0] fetch_tag_t;
    typedef logic [`FETCH_HISTORY_WIDTH-1:0] fetch_history_t;

    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] fetch_counter_t;

    // redirect and update command coming back from execute
    typedef struct packed {
        fetch_pc_t      current_pc;
        fetch_pc_t      actual_next_pc;
        logic           branched;
        logic           jumped;
        logic           update_pc;
        logic           mispredicted;
        logic           halt;
        fetch_counter_t history;
    } fetch_jump_t;

    typedef struct packed {
        logic           hit;
        fetch_counter_t counter;
    } fetch_prediction_t;

    // instruction command handed to decode
    typedef struct packed {
        fetch_pc_t         pc;
        fetch_pc_t         next_pc;
        logic              pc_updated;
        fetch_prediction_t prediction;
    } fetch_command_t;

    // one line of the branch target table
    typedef struct packed {
        logic       valid;
        fetch_tag_t tag;
        fetch_pc_t  target;
        logic       is_jump;
    } fetch_target_entry_t;

endpackage

/* rtl/fetch_settings.svh */
//**************************************************************************
// sizes and the reset address of the instruction fetch stage
// the tag width follows from pc width and index width, with the two low
// pc bits dropped because instructions are word aligned
// the counter table has 2**FETCH_HISTORY_WIDTH entries
// the target table has 2**FETCH_TABLE_ADDR_WIDTH entries and needs that
// many cycles after reset to clear itself
//**************************************************************************

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address width of the core
`define FETCH_PC_WIDTH 32

// index bits of the branch target table, taken from pc[6:2]
`define FETCH_TABLE_ADDR_WIDTH 5

// global history length, also the counter table index width
`define FETCH_HISTORY_WIDTH 6

// first pc fetched after reset
`define FETCH_START_ADDR 32'h0000_0100

`endif

/* rtl/fetch_target_table.sv */
//**************************************************************************
// direct-mapped branch target table, indexed by pc[6:2], tagged by pc[31:7]
// after reset every entry is cleared by a sweep of one entry per cycle,
// ready stays low until the sweep is over and writes are ignored before
// a write is visible to lookups from the next cycle on
//**************************************************************************

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_target_table (
    input  logic                          clk,
    input  logic                          reset,
    input  fetch_pkg::fetch_pc_t          lookup_pc,
    output fetch_pkg::fetch_target_entry_t entry,
    output logic                          hit,
    input  logic                          write_valid,
    input  fetch_pkg::fetch_pc_t          write_pc,
    input  fetch_pkg::fetch_pc_t          write_target,
    input  logic                          write_is_jump,
    output logic                          ready
);

    localparam int DEPTH = 1 << `FETCH_TABLE_ADDR_WIDTH;

    fetch_pkg::fetch_target_entry_t table_q [DEPTH];
    fetch_pkg::fetch_target_entry_t write_entry;
    fetch_pkg::fetch_table_index_t  lookup_index;
    fetch_pkg::fetch_table_index_t  write_index;
    fetch_pkg::fetch_table_index_t  sweep_index;
    logic                           sweep_done;

    // sweep counter, one entry per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_index <= '0;
            sweep_done  <= 1'b0;
        end else if (!sweep_done) begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_index == '1) begin
                sweep_done <= 1'b1;
            end
        end
    end

    assign ready = sweep_done;

    always_comb begin
        write_index         = write_pc[`FETCH_TABLE_ADDR_WIDTH+1:2];
        write_entry.valid   = 1'b1;
        write_entry.tag     = write_pc[`FETCH_PC_WIDTH-1:`FETCH_TABLE_ADDR_WIDTH+2];
        write_entry.target  = write_target;
        write_entry.is_jump = write_is_jump;
    end

    // clearing has priority until the whole table is swept
    always_ff @(posedge clk) begin
        if (!sweep_done) begin
            table_q[sweep_index] <= '0;
        end else if (write_valid) begin
            table_q[write_index] <= write_entry;
        end
    end

    always_comb begin
        lookup_index = lookup_pc[`FETCH_TABLE_ADDR_WIDTH+1:2];
        entry        = table_q[lookup_index];
        // entries not yet swept may hold garbage
        hit = sweep_done && entry.valid &&
              (entry.tag == lookup_pc[`FETCH_PC_WIDTH-1:`FETCH_TABLE_ADDR_WIDTH+2]);
    end

endmodule

/* rtl/fetch_top.sv */
//**************************************************************************
// instruction fetch stage with target table and global-history predictor
// no output is valid until 32 cycles after reset, while the target table
// clears itself
// jump commands have no ready and are taken in the cycle they are valid
//**************************************************************************

`timescale 1ns/1ps

module fetch_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      jump_valid,
    input  fetch_pkg::fetch_jump_t    jump,
    output logic                      instr_cmd_valid,
    output fetch_pkg::fetch_command_t instr_cmd,
    input  logic                      instr_cmd_ready,
    output logic                      instr_req_valid,
    output fetch_pkg::fetch_pc_t      instr_req_addr,
    input  logic                      instr_req_ready
);

    localparam int CMD_WIDTH = $bits(fetch_pkg::fetch_command_t);
    localparam int REQ_WIDTH = $bits(fetch_pkg::fetch_pc_t);

    fetch_pkg::fetch_pc_t           lookup_pc;
    fetch_pkg::fetch_target_entry_t entry;
    logic                           hit;
    logic                           table_ready;
    logic                           table_write_valid;
    fetch_pkg::fetch_counter_t      counter;

    logic                      cmd_valid;
    logic                      cmd_ready;
    fetch_pkg::fetch_command_t cmd;
    logic                      req_valid;
    logic                      req_ready;
    fetch_pkg::fetch_pc_t      req_addr;

    fetch_target_table i_fetch_target_table (
        .clk           (clk),
        .reset         (reset),
        .lookup_pc     (lookup_pc),
        .entry         (entry),
        .hit           (hit),
        .write_valid   (table_write_valid),
        .write_pc      (jump.current_pc),
        .write_target  (jump.actual_next_pc),
        .write_is_jump (jump.jumped),
        .ready         (table_ready)
    );

    fetch_direction_predictor i_fetch_direction_predictor (
        .clk                (clk),
        .reset              (reset),
        .prediction         (counter),
        .update_valid       (table_write_valid),
        .branched           (jump.branched),
        .history_at_predict (jump.history)
    );

    fetch_pc_unit i_fetch_pc_unit (
        .clk               (clk),
        .reset             (reset),
        .jump_valid        (jump_valid),
        .jump              (jump),
        .lookup_pc         (lookup_pc),
        .entry             (entry),
        .hit               (hit),
        .table_ready       (table_ready),
        .counter           (counter),
        .table_write_valid (table_write_valid),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .cmd_ready         (cmd_ready),
        .req_valid         (req_valid),
        .req_addr          (req_addr),
        .req_ready         (req_ready)
    );

    fetch_output_stage #(
        .WIDTH (CMD_WIDTH)
    ) i_cmd_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmd_valid),
        .in_data   (cmd),
        .in_ready  (cmd_ready),
        .out_valid (instr_cmd_valid),
        .out_data  (instr_cmd),
        .out_ready (instr_cmd_ready)
    );

    fetch_output_stage #(
        .WIDTH (REQ_WIDTH)
    ) i_req_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_data   (req_addr),
        .in_ready  (req_ready),
        .out_valid (instr_req_valid),
        .out_data  (instr_req_addr),
        .out_ready (instr_req_ready)
    );

endmodule

/* tb.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_target_table.sv
rtl/fetch_direction_predictor.sv
rtl/fetch_pc_unit.sv
rtl/fetch_output_stage.sv
rtl/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

/* testbench/fetch_checker.sv */
//**************************************************************************
// concurrent checks on the fetch stage, bound into fetch_top
// ports connect by name to the top level ports and the table ready net
//**************************************************************************

`timescale 1ns/1ps

module fetch_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      table_ready,
    input logic                      instr_cmd_valid,
    input fetch_pkg::fetch_command_t instr_cmd,
    input logic                      instr_cmd_ready,
    input logic                      instr_req_valid,
    input fetch_pkg::fetch_pc_t      instr_req_addr,
    input logic                      instr_req_ready
);

    // assertion failures seen so far
    int failures = 0;
    // commands delivered minus requests delivered
    int lead;

    always_ff @(posedge clk) begin
        if (reset) begin
            lead <= 0;
        end else begin
            lead <= lead + int'(instr_cmd_valid && instr_cmd_ready)
                         - int'(instr_req_valid && instr_req_ready);
        end
    end

    // held data under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        instr_cmd_valid && !instr_cmd_ready |=> instr_cmd_valid && $stable(instr_cmd))
        else begin
            failures++;
            $error("instr_cmd changed while stalled");
        end
    assert property (@(posedge clk) disable iff (reset)
        instr_req_valid && !instr_req_ready |=> instr_req_valid && $stable(instr_req_addr))
        else begin
            failures++;
            $error("instr_req changed while stalled");
        end

    assert property (@(posedge clk) reset |=> !instr_cmd_valid && !instr_req_valid)
        else begin
            failures++;
            $error("valid high after reset");
        end
    assert property (@(posedge clk) disable iff (reset)
        !table_ready |-> !instr_cmd_valid && !instr_req_valid)
        else begin
            failures++;
            $error("valid high during the table sweep");
        end

    // each stream buffers at most two fetches, so neither can lead by more
    assert property (@(posedge clk) disable iff (reset)
        lead <= 2 && lead >= -2)
        else begin
            failures++;
            $error("command and request streams out of step");
        end

    // with equal counts delivered both heads belong to the same fetch
    assert property (@(posedge clk) disable iff (reset)
        instr_cmd_valid && instr_req_valid && lead == 0 |-> instr_cmd.pc == instr_req_addr)
        else begin
            failures++;
            $error("command and request heads belong to different fetches");
        end

endmodule

bind fetch_top fetch_checker i_fetch_checker (.*);

/* testbench/fetch_input.txt */
# c total commands | r ready_mode(0 always,1 random) command_count
# j current_pc actual_next_pc branched jumped update_pc mispredicted halt history
c 51
r 0 4
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
j 00000140 00000400 1 0 0 0 0 1
r 0 20
j 0000040c 00000500 0 1 1 0 0 1
j 00000600 0000040c 0 0 1 0 0 1
r 1 40
j 00000700 00000000 0 0 1 1 1 0
r 0 48
j 00000800 00000000 0 0 0 0 1 1
r 0 51

/* testbench/fetch_tb.sv */
//**************************************************************************
// testbench for the fetch stage, driven by records from fetch_input.txt
// jump commands are applied only while both streams are stalled, so that
// exactly two commands are in flight when a jump takes effect
// the reference model predicts every command from the next-pc rule
// runs from the project root, the stimulus path is relative to it
//**************************************************************************

`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_tb;

    localparam int SWEEP_CYCLES = 1 << `FETCH_TABLE_ADDR_WIDTH;
    localparam int MAX_CMDS     = 256;

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    logic                      jump_valid = 1'b0;
    fetch_pkg::fetch_jump_t    jump = '0;
    logic                      instr_cmd_valid;
    fetch_pkg::fetch_command_t instr_cmd;
    logic                      instr_cmd_ready = 1'b0;
    logic                      instr_req_valid;
    fetch_pkg::fetch_pc_t      instr_req_addr;
    logic                      instr_req_ready = 1'b0;

    // ready mode: 0 always ready, 1 random, 2 stalled
    int          mode = 0;
    int          seed = 5;
    logic [31:0] rnd;
    int          cycle_count = 0;
    int          cycle_limit = 10000;
    int          errors = 0;
    int          mismatches = 0;
    int          cmd_count = 0;
    int          req_count = 0;
    int          expected_total = 0;

    // reference model state
    logic                      mt_valid [32];
    fetch_pkg::fetch_tag_t     mt_tag [32];
    fetch_pkg::fetch_pc_t      mt_target [32];
    logic                      mt_jump [32];
    fetch_pkg::fetch_counter_t ctab [64];
    fetch_pkg::fetch_history_t hist = '0;
    fetch_pkg::fetch_pc_t      model_pc = `FETCH_START_ADDR;
    logic                      model_updated = 1'b0;
    logic                      halt_seen = 1'b0;
    int                        gen_count = 0;
    fetch_pkg::fetch_command_t exp_cmd [MAX_CMDS];

    fetch_top i_fetch_top (
        .clk             (clk),
        .reset           (reset),
        .jump_valid      (jump_valid),
        .jump            (jump),
        .instr_cmd_valid (instr_cmd_valid),
        .instr_cmd       (instr_cmd),
        .instr_cmd_ready (instr_cmd_ready),
        .instr_req_valid (instr_req_valid),
        .instr_req_addr  (instr_req_addr),
        .instr_req_ready (instr_req_ready)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 32; i++) begin
            mt_valid[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            ctab[i] = 2'd1;
        end
    end

    function automatic fetch_pkg::fetch_counter_t saturate_step(
        input fetch_pkg::fetch_counter_t value,
        input logic                      taken
    );
        case ({taken, value})
            3'b111:  return 2'd3;
            3'b000:  return 2'd0;
            default: return taken ? value + 2'd1 : value - 2'd1;
        endcase
    endfunction

    // extend the expected sequence up to and including index
    task automatic ensure_expected(input int index);
        fetch_pkg::fetch_table_index_t idx;
        fetch_pkg::fetch_command_t     c;
        logic                          taken;
        while (gen_count <= index && !halt_seen) begin
            idx                  = model_pc[`FETCH_TABLE_ADDR_WIDTH+1:2];
            c.pc                 = model_pc;
            c.pc_updated         = model_updated;
            c.prediction.hit     = mt_valid[idx] &&
                                   mt_tag[idx] == model_pc[31:`FETCH_TABLE_ADDR_WIDTH+2];
            c.prediction.counter = ctab[hist];
            taken   = c.prediction.hit && (c.prediction.counter >= 2'd2 || mt_jump[idx]);
            c.next_pc            = taken ? mt_target[idx] : model_pc + 32'd4;
            exp_cmd[gen_count]   = c;
            gen_count++;
            model_pc      = c.next_pc;
            model_updated = 1'b0;
        end
        assert (gen_count > index) else begin
            errors++;
            $display("command %0d was fetched after halt", index);
        end
    endtask

    task automatic run_until(input int new_mode, input int target);
        mode <= new_mode;
        while (cmd_count < target || req_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_jump(input fetch_pkg::fetch_jump_t rec);
        fetch_pkg::fetch_table_index_t idx;
        int                            behind;
        mode <= 2;
        repeat (6) @(negedge clk);
        // the stream that is behind holds two commands once stalled
        behind = (cmd_count < req_count) ? cmd_count : req_count;
        ensure_expected(behind + 1);
        if (!rec.mispredicted) begin
            idx            = rec.current_pc[`FETCH_TABLE_ADDR_WIDTH+1:2];
            mt_valid[idx]  = 1'b1;
            mt_tag[idx]    = rec.current_pc[31:`FETCH_TABLE_ADDR_WIDTH+2];
            mt_target[idx] = rec.actual_next_pc;
            mt_jump[idx]   = rec.jumped;
            ctab[hist]     = saturate_step(rec.history, rec.branched);
            hist           = {hist[`FETCH_HISTORY_WIDTH-2:0], rec.branched};
            if (rec.update_pc) begin
                model_pc      = rec.actual_next_pc;
                model_updated = 1'b1;
            end
            if (rec.halt) begin
                halt_seen = 1'b1;
            end
        end
        @(posedge clk);
        jump_valid <= 1'b1;
        jump       <= rec;
        @(posedge clk);
        jump_valid <= 1'b0;
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        rnd = $random(seed);
        case (mode)
            0: begin
                instr_cmd_ready <= 1'b1;
                instr_req_ready <= 1'b1;
            end
            1: begin
                instr_cmd_ready <= rnd[0];
                instr_req_ready <= rnd[1];
            end
            default: begin
                instr_cmd_ready <= 1'b0;
                instr_req_ready <= 1'b0;
            end
        endcase
    end

    // monitor, n-th command and n-th request both match the n-th model pc
    always @(posedge clk) begin
        if (!reset && instr_cmd_valid && instr_cmd_ready) begin
            ensure_expected(cmd_count);
            assert (instr_cmd == exp_cmd[cmd_count]) else begin
                errors++;
                mismatches++;
                $display("MISMATCH at %0t: instr_cmd[%0d] = %h, expected %h",
                         $time, cmd_count, instr_cmd, exp_cmd[cmd_count]);
            end
            cmd_count++;
        end
        if (!reset && instr_req_valid && instr_req_ready) begin
            ensure_expected(req_count);
            assert (instr_req_addr == exp_cmd[req_count].pc) else begin
                errors++;
                mismatches++;
                $display("MISMATCH at %0t: instr_req_addr[%0d] = %h, expected %h",
                         $time, req_count, instr_req_addr, exp_cmd[req_count].pc);
            end
            req_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, fetch stopped making progress", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int                     fd;
        int                     code;
        logic [7:0]             kind;
        logic [1023:0]          line;
        fetch_pkg::fetch_pc_t   cur;
        fetch_pkg::fetch_pc_t   nxt;
        int                     br;
        int                     jm;
        int                     up;
        int                     mis;
        int                     hl;
        int                     hv;
        int                     m;
        int                     target;
        fetch_pkg::fetch_jump_t rec;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        fd = $fopen("testbench/fetch_input.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("cannot open the stimulus file testbench/fetch_input.txt");
        end
        while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(line, fd);
                "c": begin
                    code = $fscanf(fd, "%d", expected_total);
                    assert (code == 1) else begin
                        errors++;
                        $display("malformed count record in the stimulus file");
                    end
                    cycle_limit = expected_total * 4 + 100 + SWEEP_CYCLES;
                end
                "r": begin
                    code = $fscanf(fd, "%d %d", m, target);
                    assert (code == 2) else begin
                        errors++;
                        $display("malformed ready record in the stimulus file");
                    end
                    run_until(m, target);
                end
                "j": begin
                    code = $fscanf(fd, "%h %h %d %d %d %d %d %d",
                                   cur, nxt, br, jm, up, mis, hl, hv);
                    assert (code == 8) else begin
                        errors++;
                        $display("malformed jump record in the stimulus file");
                    end
                    rec.current_pc     = cur;
                    rec.actual_next_pc = nxt;
                    rec.branched       = br[0];
                    rec.jumped         = jm[0];
                    rec.update_pc      = up[0];
                    rec.mispredicted   = mis[0];
                    rec.halt           = hl[0];
                    rec.history        = hv[1:0];
                    apply_jump(rec);
                end
                default: begin
                    errors++;
                    $display("unknown record kind '%c' in the stimulus file", kind);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        // after halt nothing may leave the stage any more
        repeat (20) begin
            @(negedge clk);
            assert (!instr_cmd_valid && !instr_req_valid) else begin
                errors++;
                $display("a valid rose at %0t after fetch was halted", $time);
            end
        end
        assert (i_fetch_top.i_fetch_checker.failures == 0) else begin
            errors++;
            $display("the bound checker saw %0d assertion failures",
                     i_fetch_top.i_fetch_checker.failures);
        end
        assert (cmd_count == expected_total && req_count == expected_total) else begin
            errors++;
            $display("expected %0d commands and requests, saw %0d and %0d",
                     expected_total, cmd_count, req_count);
        end
        $display("errors %0d, mismatches %0d, commands %0d, requests %0d",
                 errors, mismatches, cmd_count, req_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
